// File: Makefile
TOP = tb_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vec_proc.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// File: design/vec_alu.sv
`timescale 1ns/10ps
`default_nettype none

module vec_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  vec_pkg::alu_req_t req,
    output logic              wr_valid,
    output vec_pkg::vaddr_t   wr_addr,
    output vec_pkg::vreg_t    wr_data,
    output vec_pkg::byte_en_t wr_be
);

    logic           is_sub;
    logic [2:0]     lane_mask;  // byte index bits inside one lane
    vec_pkg::vreg_t b_eff;
    vec_pkg::vreg_t sum;
    vec_pkg::vreg_t result;

    assign is_sub = (req.funct6 == vec_pkg::F6_SUB);
    assign b_eff  = is_sub ? ~req.b : req.b;  // a - b as a + ~b + 1

    always_comb begin
        case (req.sew)
            2'd0:    lane_mask = 3'b000;
            2'd1:    lane_mask = 3'b001;
            2'd2:    lane_mask = 3'b011;
            default: lane_mask = 3'b111;
        endcase
    end

    // byte-wide carry chain, restarted at the first byte of every lane
    always_comb begin
        logic       carry;
        logic [8:0] partial;
        carry   = 1'b0;
        partial = '0;
        for (int i = 0; i < vec_pkg::VLEN_B; i++) begin
            if ((3'(i) & lane_mask) == 3'b000) carry = is_sub;
            partial = {1'b0, req.a[i*8 +: 8]} + {1'b0, b_eff[i*8 +: 8]} + {8'd0, carry};
            sum[i*8 +: 8] = partial[7:0];
            carry = partial[8];  // lanes wrap, the last carry is dropped
        end
    end

    always_comb begin
        case (req.funct6)
            vec_pkg::F6_ADD,
            vec_pkg::F6_SUB: result = sum;
            vec_pkg::F6_AND: result = req.a & req.b;
            vec_pkg::F6_OR:  result = req.a | req.b;
            vec_pkg::F6_XOR: result = req.a ^ req.b;
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_valid <= 1'b0;
            wr_be    <= '0;
        end else begin
            wr_valid <= req.valid;
            wr_be    <= req.valid ? req.byte_en : '0;  // regfile writes on be alone
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            wr_addr <= req.vd;
            wr_data <= result;
        end
    end

endmodule

`default_nettype wire

// File: design/vec_cfg_unit.sv
`timescale 1ns/10ps
`default_nettype none

module vec_cfg_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_issue,
    input  vec_pkg::dec_insn_t dec,
    input  vec_pkg::xdata_t    avl,
    output vec_pkg::sew_t      sew,
    output vec_pkg::byte_en_t  tail_be,
    output vec_pkg::xdata_t    new_vl
);

    vec_pkg::vl_t vl;
    vec_pkg::vl_t vlmax;
    vec_pkg::vl_t vl_nxt;

    assign vlmax = vec_pkg::vl_t'(4'd8 >> dec.vsew);  // one register, LMUL fixed at 1

    always_comb begin
        if (!dec.rs1_zero) begin
            vl_nxt = (avl < vec_pkg::xdata_t'(vlmax)) ? vec_pkg::vl_t'(avl) : vlmax;
        end else if (!dec.rd_zero) begin
            vl_nxt = vlmax;
        end else begin
            vl_nxt = vl;  // x0, x0 keeps vl
        end
    end

    assign new_vl = vec_pkg::xdata_t'(vl_nxt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sew <= 2'd0;
            vl  <= 4'd8;
        end else if (cfg_issue) begin
            sew <= dec.vsew;
            vl  <= vl_nxt;
        end
    end

    // byte b belongs to element b >> sew, tail elements stay untouched
    always_comb begin
        for (int b = 0; b < vec_pkg::VLEN_B; b++) begin
            tail_be[b] = vec_pkg::vl_t'(b >> sew) < vl;
        end
    end

endmodule

`default_nettype wire

// File: design/vec_insn_decode.sv
`timescale 1ns/10ps
`default_nettype none

module vec_insn_decode (
    input  vec_pkg::insn_t     insn,
    output vec_pkg::dec_insn_t dec
);

    logic [6:0] opcode;
    logic [2:0] mnr;
    logic       op_vec;
    logic       arith_form;
    logic       f6_ok;

    assign opcode = insn[6:0];
    assign mnr    = insn[14:12];
    assign op_vec = (opcode == vec_pkg::OPC_VEC);

    assign arith_form = op_vec & ((mnr == vec_pkg::MNR_IVV) |
                                  (mnr == vec_pkg::MNR_IVX) |
                                  (mnr == vec_pkg::MNR_IVI));

    always_comb begin
        case (insn[31:26])
            vec_pkg::F6_ADD,
            vec_pkg::F6_SUB,
            vec_pkg::F6_AND,
            vec_pkg::F6_OR,
            vec_pkg::F6_XOR: f6_ok = 1'b1;
            default:         f6_ok = 1'b0;  // anything else issues as a no-op
        endcase
    end

    always_comb begin
        dec.mnr    = mnr;
        dec.funct6 = insn[31:26];
        dec.vd     = insn[11:7];
        dec.vs1    = insn[19:15];
        dec.vs2    = insn[24:20];
        dec.simm5  = insn[19:15];
        // vsew sits in vtype[5:3], only codes 0..3 are kept
        dec.vsew     = insn[24:23];
        dec.rd_zero  = (insn[11:7] == 5'd0);
        dec.rs1_zero = (insn[19:15] == 5'd0);

        dec.is_load  = (opcode == vec_pkg::OPC_LOAD);
        dec.is_store = (opcode == vec_pkg::OPC_STORE);
        dec.is_alu   = arith_form & f6_ok;
        dec.is_cfg   = op_vec & (mnr == vec_pkg::MNR_CFG) & ~insn[31];  // vsetvli form

        dec.uses_vs1    = dec.is_alu & (mnr == vec_pkg::MNR_IVV);
        dec.uses_vs2    = dec.is_alu;
        dec.uses_vd_src = dec.is_store;
    end

endmodule

`default_nettype wire

// File: design/vec_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module vec_mem_port (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            st_issue,
    input  logic            ld_issue,
    input  vec_pkg::vaddr_t vd,
    input  vec_pkg::xdata_t addr,
    input  vec_pkg::vreg_t  st_data,
    input  vec_pkg::vreg_t  mem_rdata,
    input  logic            mem_rvalid,
    output logic            mem_req,
    output logic            mem_wvalid,
    output vec_pkg::xdata_t mem_addr,
    output vec_pkg::vreg_t  mem_wdata,
    output logic            ld_busy,
    output logic            ld_wr_en,
    output vec_pkg::vaddr_t ld_wr_addr,
    output vec_pkg::vreg_t  ld_wr_data
);

    // first rvalid while a load is open ends it, stray rvalid is dropped
    assign ld_wr_en   = ld_busy & mem_rvalid;
    assign ld_wr_data = mem_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_req    <= 1'b0;
            mem_wvalid <= 1'b0;
            ld_busy    <= 1'b0;
        end else begin
            mem_req    <= ld_issue;  // single-cycle strobes
            mem_wvalid <= st_issue;
            if (ld_issue) begin
                ld_busy <= 1'b1;
            end else if (ld_wr_en) begin
                ld_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st_issue || ld_issue) mem_addr <= addr;
        if (st_issue) mem_wdata <= st_data;
        if (ld_issue) ld_wr_addr <= vd;  // destination held until data returns
    end

endmodule

`default_nettype wire

// File: design/vec_pkg.sv
`default_nettype none

package vec_pkg;

    localparam int NUM_VEC = 32;         // architectural vector registers
    localparam int VLEN    = 64;         // bits per vector register
    localparam int VLEN_B  = VLEN / 8;   // bytes per vector register

    typedef logic [31:0]       insn_t;
    typedef logic [VLEN-1:0]   vreg_t;
    typedef logic [4:0]        vaddr_t;
    typedef logic [VLEN_B-1:0] byte_en_t;
    typedef logic [1:0]        sew_t;     // 0=e8 1=e16 2=e32 3=e64
    typedef logic [3:0]        vl_t;      // 0..8 elements
    typedef logic [31:0]       xdata_t;
    typedef logic [5:0]        funct6_t;

    // major opcodes
    localparam logic [6:0] OPC_LOAD  = 7'h07;
    localparam logic [6:0] OPC_STORE = 7'h27;
    localparam logic [6:0] OPC_VEC   = 7'h57;

    // minor types in funct3 of OPC_VEC
    localparam logic [2:0] MNR_IVV = 3'd0;
    localparam logic [2:0] MNR_IVI = 3'd3;
    localparam logic [2:0] MNR_IVX = 3'd4;
    localparam logic [2:0] MNR_CFG = 3'd7;

    localparam funct6_t F6_ADD = 6'h00;
    localparam funct6_t F6_SUB = 6'h02;
    localparam funct6_t F6_AND = 6'h09;
    localparam funct6_t F6_OR  = 6'h0A;
    localparam funct6_t F6_XOR = 6'h0B;

    typedef struct packed {
        logic       is_load;
        logic       is_store;
        logic       is_alu;       // supported arithmetic op only
        logic       is_cfg;       // vsetvli
        logic [2:0] mnr;
        funct6_t    funct6;
        vaddr_t     vd;           // vd, or vs3 for stores
        vaddr_t     vs1;
        vaddr_t     vs2;
        logic [4:0] simm5;
        sew_t       vsew;
        logic       rd_zero;
        logic       rs1_zero;
        logic       uses_vs1;
        logic       uses_vs2;
        logic       uses_vd_src;  // vd read as store data
    } dec_insn_t;

    typedef struct packed {
        logic     valid;
        funct6_t  funct6;
        vaddr_t   vd;
        vreg_t    a;              // vs2
        vreg_t    b;              // vs1, scalar or immediate
        sew_t     sew;
        byte_en_t byte_en;
    } alu_req_t;

endpackage

`default_nettype wire

// File: design/vec_proc_top.sv
`timescale 1ns/10ps
`default_nettype none

module vec_proc_top (
    input  logic            clk,
    input  logic            rst_n,
    input  vec_pkg::insn_t  insn,
    input  logic            insn_valid,
    input  vec_pkg::xdata_t scalar_in,
    input  vec_pkg::vreg_t  mem_rdata,
    input  logic            mem_rvalid,
    output logic            proc_rdy,
    output logic            mem_req,
    output vec_pkg::xdata_t mem_addr,
    output vec_pkg::vreg_t  mem_wdata,
    output logic            mem_wvalid,
    output vec_pkg::xdata_t scalar_out,
    output logic            scalar_valid
);

    vec_pkg::insn_t     fetch_insn;
    vec_pkg::xdata_t    fetch_scalar;
    logic               fetch_valid;
    vec_pkg::dec_insn_t dec;
    logic               stall;
    logic               issue;
    vec_pkg::vaddr_t    rd_addr_b;
    vec_pkg::vreg_t     rd_data_a;
    vec_pkg::vreg_t     rd_data_b;
    vec_pkg::sew_t      sew;
    vec_pkg::byte_en_t  tail_be;
    vec_pkg::xdata_t    new_vl;
    vec_pkg::alu_req_t  alu_req;
    logic               alu_wr_valid;
    vec_pkg::vaddr_t    alu_wr_addr;
    vec_pkg::vreg_t     alu_wr_data;
    vec_pkg::byte_en_t  alu_wr_be;
    logic               ld_busy;
    logic               ld_wr_en;
    vec_pkg::vaddr_t    ld_wr_addr;
    vec_pkg::vreg_t     ld_wr_data;
    vec_pkg::vreg_t     b_operand;

    // copy the low sew bits of val into every lane
    function automatic vec_pkg::vreg_t splat(input vec_pkg::vreg_t val, input vec_pkg::sew_t s);
        case (s)
            2'd0:    return {8{val[7:0]}};
            2'd1:    return {4{val[15:0]}};
            2'd2:    return {2{val[31:0]}};
            default: return val;
        endcase
    endfunction

    assign proc_rdy = rst_n & ~stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else if (insn_valid && proc_rdy) begin
            fetch_valid <= 1'b1;
        end else if (issue) begin
            fetch_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (insn_valid && proc_rdy) begin
            fetch_insn   <= insn;
            fetch_scalar <= scalar_in;
        end
    end

    vec_insn_decode i_decode (
        .insn (fetch_insn),
        .dec  (dec)
    );

    vec_scoreboard i_scoreboard (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec),
        .fetch_valid  (fetch_valid),
        .alu_wr_valid (alu_wr_valid),
        .alu_wr_addr  (alu_wr_addr),
        .ld_wr_valid  (ld_wr_en),
        .ld_wr_addr   (ld_wr_addr),
        .ld_busy      (ld_busy),
        .stall        (stall),
        .issue        (issue)
    );

    assign rd_addr_b = dec.uses_vd_src ? dec.vd : dec.vs1;  // port b doubles as store read

    vec_regfile i_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_addr_a   (dec.vs2),
        .rd_addr_b   (rd_addr_b),
        .alu_wr_addr (alu_wr_addr),
        .alu_wr_data (alu_wr_data),
        .alu_wr_be   (alu_wr_be),
        .ld_wr_en    (ld_wr_en),
        .ld_wr_addr  (ld_wr_addr),
        .ld_wr_data  (ld_wr_data),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b)
    );

    vec_cfg_unit i_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_issue (issue & dec.is_cfg),
        .dec       (dec),
        .avl       (fetch_scalar),
        .sew       (sew),
        .tail_be   (tail_be),
        .new_vl    (new_vl)
    );

    always_comb begin
        case (dec.mnr)
            vec_pkg::MNR_IVX: b_operand = splat({{32{fetch_scalar[31]}}, fetch_scalar}, sew);
            vec_pkg::MNR_IVI: b_operand = splat({{59{dec.simm5[4]}}, dec.simm5}, sew);
            default:          b_operand = rd_data_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_req.valid <= 1'b0;
        end else begin
            alu_req.valid <= issue & dec.is_alu;
        end
        if (issue && dec.is_alu) begin
            alu_req.funct6  <= dec.funct6;
            alu_req.vd      <= dec.vd;
            alu_req.a       <= rd_data_a;
            alu_req.b       <= b_operand;
            alu_req.sew     <= sew;      // config in force at issue
            alu_req.byte_en <= tail_be;
        end
    end

    vec_alu i_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (alu_req),
        .wr_valid (alu_wr_valid),
        .wr_addr  (alu_wr_addr),
        .wr_data  (alu_wr_data),
        .wr_be    (alu_wr_be)
    );

    vec_mem_port i_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .st_issue   (issue & dec.is_store),
        .ld_issue   (issue & dec.is_load),
        .vd         (dec.vd),
        .addr       (fetch_scalar),
        .st_data    (rd_data_b),
        .mem_rdata  (mem_rdata),
        .mem_rvalid (mem_rvalid),
        .mem_req    (mem_req),
        .mem_wvalid (mem_wvalid),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .ld_busy    (ld_busy),
        .ld_wr_en   (ld_wr_en),
        .ld_wr_addr (ld_wr_addr),
        .ld_wr_data (ld_wr_data)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scalar_valid <= 1'b0;
        end else begin
            scalar_valid <= issue & dec.is_cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (issue && dec.is_cfg) scalar_out <= new_vl;  // vl returned to the scalar core
    end

endmodule

`default_nettype wire

// File: design/vec_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module vec_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  vec_pkg::vaddr_t   rd_addr_a,
    input  vec_pkg::vaddr_t   rd_addr_b,
    input  vec_pkg::vaddr_t   alu_wr_addr,
    input  vec_pkg::vreg_t    alu_wr_data,
    input  vec_pkg::byte_en_t alu_wr_be,
    input  logic              ld_wr_en,
    input  vec_pkg::vaddr_t   ld_wr_addr,
    input  vec_pkg::vreg_t    ld_wr_data,
    output vec_pkg::vreg_t    rd_data_a,
    output vec_pkg::vreg_t    rd_data_b
);

    vec_pkg::vreg_t regs [vec_pkg::NUM_VEC];

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < vec_pkg::NUM_VEC; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (ld_wr_en) begin
                regs[ld_wr_addr] <= ld_wr_data;  // loads write the whole register
            end
            for (int b = 0; b < vec_pkg::VLEN_B; b++) begin
                if (alu_wr_be[b]) regs[alu_wr_addr][b*8 +: 8] <= alu_wr_data[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/vec_scoreboard.sv
`timescale 1ns/10ps
`default_nettype none

module vec_scoreboard (
    input  logic               clk,
    input  logic               rst_n,
    input  vec_pkg::dec_insn_t dec,
    input  logic               fetch_valid,
    input  logic               alu_wr_valid,
    input  vec_pkg::vaddr_t    alu_wr_addr,
    input  logic               ld_wr_valid,
    input  vec_pkg::vaddr_t    ld_wr_addr,
    input  logic               ld_busy,
    output logic               stall,
    output logic               issue
);

    logic [vec_pkg::NUM_VEC-1:0] pending;  // one bit per vector register
    logic                        writes_vd;
    logic                        hazard;

    assign writes_vd = dec.is_alu | dec.is_load;

    // RAW on sources, WAW on vd, and a single outstanding load
    assign hazard = (dec.uses_vs1 & pending[dec.vs1])
                  | (dec.uses_vs2 & pending[dec.vs2])
                  | ((dec.uses_vd_src | writes_vd) & pending[dec.vd])
                  | (dec.is_load & ld_busy);

    assign stall = fetch_valid & hazard;
    assign issue = fetch_valid & ~hazard;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (alu_wr_valid) pending[alu_wr_addr] <= 1'b0;
            if (ld_wr_valid) pending[ld_wr_addr] <= 1'b0;
            if (issue && writes_vd) pending[dec.vd] <= 1'b1;  // new owner wins
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mem_req,
    input  vec_pkg::xdata_t mem_addr,
    input  logic            mem_wvalid,
    input  vec_pkg::vreg_t  mem_wdata,
    input  logic            scalar_valid,
    input  vec_pkg::xdata_t scalar_out,
    output int              errors
);

    vec_pkg::xdata_t st_addr_q [$];
    vec_pkg::vreg_t  st_data_q [$];
    vec_pkg::xdata_t ld_addr_q [$];
    vec_pkg::xdata_t vl_q [$];
    int              err_cnt = 0;
    int              n_st = 0;
    int              n_ld = 0;
    int              n_vl = 0;

    assign errors = err_cnt;

    // filled by the reference model in program order
    task automatic expect_store(input vec_pkg::xdata_t addr, input vec_pkg::vreg_t data);
        st_addr_q.push_back(addr);
        st_data_q.push_back(data);
    endtask

    task automatic expect_load(input vec_pkg::xdata_t addr);
        ld_addr_q.push_back(addr);
    endtask

    task automatic expect_vl(input vec_pkg::xdata_t vl);
        vl_q.push_back(vl);
    endtask

    function automatic int pending_count();
        return st_addr_q.size() + ld_addr_q.size() + vl_q.size();
    endfunction

    task automatic compare(input string name, input int idx, input vec_pkg::vreg_t exp,
                           input vec_pkg::vreg_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s #%0d expected %h actual %h", name, idx, exp, act);
        end
    endtask

    // registered outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && mem_wvalid) begin
            if (st_addr_q.size() == 0) begin
                err_cnt++;
                $display("ERROR: store strobe seen with no store expected, addr %h", mem_addr);
            end else begin
                compare("store_addr", n_st, 64'(st_addr_q.pop_front()), 64'(mem_addr));
                compare("store_data", n_st, st_data_q.pop_front(), mem_wdata);
                n_st++;
            end
        end
        if (rst_n && mem_req) begin
            if (ld_addr_q.size() == 0) begin
                err_cnt++;
                $display("ERROR: load request seen with no load expected, addr %h", mem_addr);
            end else begin
                compare("load_addr", n_ld, 64'(ld_addr_q.pop_front()), 64'(mem_addr));
                n_ld++;
            end
        end
        if (rst_n && scalar_valid) begin
            if (vl_q.size() == 0) begin
                err_cnt++;
                $display("ERROR: scalar result seen with no vsetvli expected");
            end else begin
                compare("vsetvli_vl", n_vl, 64'(vl_q.pop_front()), 64'(scalar_out));
                n_vl++;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_properties.sv
`timescale 1ns/10ps
`default_nettype none

module tb_properties (
    input logic clk,
    input logic rst_n,
    input logic proc_rdy,
    input logic mem_req,
    input logic mem_wvalid
);

    int failures = 0;  // read by the testbench top at the end of the run

    a_rdy_low_in_reset: assert property (@(posedge clk) !rst_n |-> !proc_rdy)
        else begin
            failures++;
            $error("proc_rdy is high while rst_n is low");
        end

    // a load request and a store never share a cycle
    a_req_wvalid_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req && mem_wvalid))
        else begin
            failures++;
            $error("mem_req and mem_wvalid are high in the same cycle");
        end

    a_req_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |=> !mem_req)
        else begin
            failures++;
            $error("mem_req is high on two consecutive cycles");
        end

endmodule

`default_nettype wire

// File: testbench/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_top;

    localparam int NUM_INSN = 400;
    localparam int TIMEOUT  = NUM_INSN * 12 + 200;

    logic            clk = 1'b0;
    logic            rst_n;
    vec_pkg::insn_t  insn;
    logic            insn_valid;
    vec_pkg::xdata_t scalar_in;
    vec_pkg::vreg_t  mem_rdata = '0;
    logic            mem_rvalid = 1'b0;
    logic            proc_rdy;
    logic            mem_req;
    vec_pkg::xdata_t mem_addr;
    vec_pkg::vreg_t  mem_wdata;
    logic            mem_wvalid;
    vec_pkg::xdata_t scalar_out;
    logic            scalar_valid;
    int              chk_errors;
    int              cycles = 0;

    vec_pkg::vreg_t  model_regs [vec_pkg::NUM_VEC];
    vec_pkg::sew_t   model_sew;
    int              model_vl;
    vec_pkg::vreg_t  load_mem [vec_pkg::xdata_t];  // load data by address
    int              load_cnt;
    int              rsp_wait = 0;
    vec_pkg::vreg_t  rsp_data = '0;

    always #5 clk = ~clk;

    vec_proc_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .insn         (insn),
        .insn_valid   (insn_valid),
        .scalar_in    (scalar_in),
        .mem_rdata    (mem_rdata),
        .mem_rvalid   (mem_rvalid),
        .proc_rdy     (proc_rdy),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_wvalid   (mem_wvalid),
        .scalar_out   (scalar_out),
        .scalar_valid (scalar_valid)
    );

    tb_checker i_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_wvalid   (mem_wvalid),
        .mem_wdata    (mem_wdata),
        .scalar_valid (scalar_valid),
        .scalar_out   (scalar_out),
        .errors       (chk_errors)
    );

    bind vec_proc_top tb_properties i_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_rdy   (proc_rdy),
        .mem_req    (mem_req),
        .mem_wvalid (mem_wvalid)
    );

    // memory responder, one load in flight, 1 to 4 cycles
    always @(negedge clk) begin
        mem_rvalid = 1'b0;
        if (rsp_wait > 0) begin
            rsp_wait--;
            if (rsp_wait == 0) begin
                mem_rvalid = 1'b1;
                mem_rdata  = rsp_data;
            end
        end else if (mem_req) begin
            rsp_data = load_mem.exists(mem_addr) ? load_mem[mem_addr] : '0;
            rsp_wait = $urandom_range(1, 4);
        end else if (rst_n && $urandom_range(0, 15) == 0) begin
            mem_rvalid = 1'b1;  // stray return, must be ignored
            mem_rdata  = {$urandom, $urandom};
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("ERROR: timeout, run still busy after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // element-wise reference for the integer ops
    task automatic model_alu(input logic [2:0] form, input vec_pkg::funct6_t f6,
                             input vec_pkg::vaddr_t vd, input vec_pkg::vaddr_t vs1,
                             input vec_pkg::vaddr_t vs2, input vec_pkg::xdata_t x);
        int             ew;
        logic [63:0]    emask;
        logic [63:0]    splat;
        logic [63:0]    ea;
        logic [63:0]    eb;
        logic [63:0]    er;
        vec_pkg::vreg_t res;
        ew    = 8 << model_sew;
        emask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
        res   = model_regs[vd];
        if (form == vec_pkg::MNR_IVX) splat = {{32{x[31]}}, x};
        else splat = {{59{vs1[4]}}, vs1};  // simm5
        for (int i = 0; i < 64 / ew; i++) begin
            ea = (model_regs[vs2] >> (i * ew)) & emask;
            if (form == vec_pkg::MNR_IVV) eb = (model_regs[vs1] >> (i * ew)) & emask;
            else eb = splat & emask;
            case (f6)
                vec_pkg::F6_ADD: er = ea + eb;
                vec_pkg::F6_SUB: er = ea - eb;
                vec_pkg::F6_AND: er = ea & eb;
                vec_pkg::F6_OR:  er = ea | eb;
                default:         er = ea ^ eb;
            endcase
            if (i < model_vl) begin  // tail elements undisturbed
                res = (res & ~(emask << (i * ew))) | ((er & emask) << (i * ew));
            end
        end
        model_regs[vd] = res;
    endtask

    // waits for proc_rdy at a falling edge, then drives the instruction
    task automatic present_insn(input vec_pkg::insn_t op, input vec_pkg::xdata_t x);
        @(negedge clk);
        while (!proc_rdy) begin
            insn_valid = ($urandom_range(0, 3) == 0);  // junk while not ready
            insn       = $urandom;
            @(negedge clk);
        end
        insn       = op;
        scalar_in  = x;
        insn_valid = 1'b1;
    endtask

    task automatic send_random();
        int               kind;
        int               vlmax;
        vec_pkg::vaddr_t  vd;
        vec_pkg::vaddr_t  vs1;
        vec_pkg::vaddr_t  vs2;
        vec_pkg::funct6_t f6;
        logic [2:0]       form;
        vec_pkg::sew_t    s;
        vec_pkg::xdata_t  x;
        vec_pkg::vreg_t   ld_data;
        kind = $urandom_range(0, 99);
        vd   = vec_pkg::vaddr_t'($urandom_range(0, 7));
        vs1  = vec_pkg::vaddr_t'($urandom_range(0, 7));
        vs2  = vec_pkg::vaddr_t'($urandom_range(0, 7));
        x    = $urandom;
        if ($urandom_range(0, 7) == 0) begin
            @(negedge clk);
            insn_valid = 1'b0;  // idle gap
        end
        if (kind < 12) begin
            s   = vec_pkg::sew_t'($urandom_range(0, 3));
            vs1 = vec_pkg::vaddr_t'($urandom_range(0, 3));  // rs1, x0 one time in four
            vd  = vec_pkg::vaddr_t'($urandom_range(0, 3));  // rd
            if ($urandom_range(0, 7) != 0) x = vec_pkg::xdata_t'($urandom_range(0, 10));
            present_insn({6'd0, 1'b0, s, 3'($urandom), vs1, 3'd7, vd, vec_pkg::OPC_VEC}, x);
            vlmax     = 8 >> s;
            model_sew = s;
            if (vs1 != 5'd0) model_vl = (x < vec_pkg::xdata_t'(vlmax)) ? int'(x) : vlmax;
            else if (vd != 5'd0) model_vl = vlmax;
            i_chk.expect_vl(vec_pkg::xdata_t'(model_vl));
        end else if (kind < 62) begin
            case ($urandom_range(0, 2))
                0:       form = vec_pkg::MNR_IVV;
                1:       form = vec_pkg::MNR_IVX;
                default: form = vec_pkg::MNR_IVI;
            endcase
            case ($urandom_range(0, 5))
                0:       f6 = vec_pkg::F6_ADD;
                1:       f6 = vec_pkg::F6_SUB;
                2:       f6 = vec_pkg::F6_AND;
                3:       f6 = vec_pkg::F6_OR;
                4:       f6 = vec_pkg::F6_XOR;
                default: f6 = vec_pkg::funct6_t'($urandom);
            endcase
            if (form != vec_pkg::MNR_IVV) vs1 = 5'($urandom);  // rs1 or simm5
            present_insn({f6, 1'b1, vs2, vs1, form, vd, vec_pkg::OPC_VEC}, x);
            if (f6 inside {vec_pkg::F6_ADD, vec_pkg::F6_SUB, vec_pkg::F6_AND,
                           vec_pkg::F6_OR, vec_pkg::F6_XOR}) begin
                model_alu(form, f6, vd, vs1, vs2, x);
            end
        end else if (kind < 77) begin
            x       = 32'h1000_0000 + vec_pkg::xdata_t'(load_cnt * 8);  // unique per load
            ld_data = {$urandom, $urandom};
            load_mem[x] = ld_data;
            load_cnt++;
            present_insn({12'h020, 5'($urandom), 3'b000, vd, vec_pkg::OPC_LOAD}, x);
            model_regs[vd] = ld_data;
            i_chk.expect_load(x);
        end else if (kind < 95) begin
            present_insn({12'h020, 5'($urandom), 3'b000, vd, vec_pkg::OPC_STORE}, x);
            i_chk.expect_store(x, model_regs[vd]);
        end else begin
            form = 3'($urandom_range(1, 2)) + (($urandom_range(0, 1) == 0) ? 3'd4 : 3'd0);
            present_insn({6'($urandom), 1'b1, vs2, vs1, form, vd,
                          ($urandom_range(0, 1) == 0) ? vec_pkg::OPC_VEC : 7'h33}, x);
        end
    endtask

    initial begin
        vec_pkg::xdata_t x;
        int              total;
        void'($urandom(32'hd223));
        rst_n      = 1'b0;
        insn       = '0;
        insn_valid = 1'b0;
        scalar_in  = '0;
        for (int r = 0; r < vec_pkg::NUM_VEC; r++) model_regs[r] = '0;
        model_sew = 2'd0;
        model_vl  = 8;
        load_cnt  = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int n = 0; n < NUM_INSN; n++) send_random();

        // read back the working registers
        for (int r = 0; r < 8; r++) begin
            x = $urandom;
            present_insn({12'h020, 5'd0, 3'b000, vec_pkg::vaddr_t'(r), vec_pkg::OPC_STORE}, x);
            i_chk.expect_store(x, model_regs[r]);
        end
        @(negedge clk);
        insn_valid = 1'b0;
        while (i_chk.pending_count() != 0) @(negedge clk);
        repeat (20) @(negedge clk);

        total = chk_errors + i_dut.i_props.failures;
        $display("run complete: %0d instructions, %0d errors", NUM_INSN + 8, total);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vec_proc.f
design/vec_pkg.sv
design/vec_insn_decode.sv
design/vec_scoreboard.sv
design/vec_regfile.sv
design/vec_cfg_unit.sv
design/vec_alu.sv
design/vec_mem_port.sv
design/vec_proc_top.sv
testbench/tb_properties.sv
testbench/tb_checker.sv
testbench/tb_top.sv
